/* hdl/csr_bus_if.sv */
// csr register block bus
`timescale 1ns/1ps

interface csr_bus_if import csr_pkg::*; ();

  // block select, one instance at a time
  logic      sel;
  // register inside the block
  csr_reg_t  idx;
  // write strobe for this cycle
  logic      we;
  // resolved write data (after set/clear)
  csr_data_t wdata;
  // block read value for idx
  csr_data_t rdata;

  // address side
  modport decoder (output sel, output idx, output we);

  // read mux and rmw data
  modport port (input sel, input rdata, output wdata);

  // register storage
  modport block (input idx, input we, input wdata, output rdata);

endinterface

/* hdl/csr_decode.sv */
// csr address decoder
`timescale 1ns/1ps
`include "csr_params.svh"

module csr_decode import csr_pkg::*; (
  input  logic      csr_access_i,
  input  csr_addr_t csr_addr_i,
  input  csr_op_t   csr_op_i,
  output logic      csr_busy_o,
  output logic      csr_illegal_o,
  csr_bus_if.decoder bus_trap,
  csr_bus_if.decoder bus_perf
);

  logic      trap_hit;
  logic      perf_hit;
  csr_reg_t  trap_idx;
  csr_reg_t  perf_idx;
  csr_addr_t pccr_off;
  logic      op_wr;

  // offset into the counter window
  assign pccr_off = csr_addr_i - `CSR_ADDR_PCCR_BASE;
  // any op but none writes
  assign op_wr    = (csr_op_i != `CSR_OP_NONE);

  ////////////////////////////////////////////////////////////////////////////
  // address map
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin
    trap_hit = 1'b0;
    perf_hit = 1'b0;
    trap_idx = '0;
    perf_idx = '0;
    case (csr_addr_i)
      `CSR_ADDR_MSTATUS: begin
        trap_hit = 1'b1;
        trap_idx = `CSR_IDX_MSTATUS;
      end
      `CSR_ADDR_MTVEC: begin
        trap_hit = 1'b1;
        trap_idx = `CSR_IDX_MTVEC;
      end
      `CSR_ADDR_MEPC: begin
        trap_hit = 1'b1;
        trap_idx = `CSR_IDX_MEPC;
      end
      `CSR_ADDR_MCAUSE: begin
        trap_hit = 1'b1;
        trap_idx = `CSR_IDX_MCAUSE;
      end
      `CSR_ADDR_PCER: begin
        perf_hit = 1'b1;
        perf_idx = `CSR_IDX_PCER;
      end
      `CSR_ADDR_PCMR: begin
        perf_hit = 1'b1;
        perf_idx = `CSR_IDX_PCMR;
      end
      `CSR_ADDR_PCCR_ALL: begin
        perf_hit = 1'b1;
        perf_idx = `CSR_IDX_PCCR_ALL;
      end
      default: begin
        // individual counters, base .. base+7
        if (pccr_off < csr_addr_t'(`CSR_N_PERF_CNT)) begin
          perf_hit = 1'b1;
          perf_idx = pccr_off[3:0];
        end
      end
    endcase
  end

  assign bus_trap.sel = trap_hit;
  assign bus_trap.idx = trap_idx;
  assign bus_trap.we  = trap_hit & op_wr;
  assign bus_perf.sel = perf_hit;
  assign bus_perf.idx = perf_idx;
  assign bus_perf.we  = perf_hit & op_wr;

  // mepc and mtvec writes stall the pipe
  assign csr_busy_o = trap_hit & op_wr &
                      ((trap_idx == `CSR_IDX_MTVEC) || (trap_idx == `CSR_IDX_MEPC));

  // nobody claimed the address
  assign csr_illegal_o = csr_access_i & ~trap_hit & ~perf_hit;

endmodule

/* hdl/csr_params.svh */
// csr block parameters
`ifndef CSR_PARAMS_SVH
`define CSR_PARAMS_SVH

////////////////////////////////////////////////////////////////////////////
// csr addresses
////////////////////////////////////////////////////////////////////////////
`define CSR_ADDR_MSTATUS   12'h300
`define CSR_ADDR_MTVEC     12'h305
`define CSR_ADDR_MEPC      12'h341
`define CSR_ADDR_MCAUSE    12'h342
`define CSR_ADDR_PCER      12'h7A0
`define CSR_ADDR_PCMR      12'h7A1
`define CSR_ADDR_PCCR_BASE 12'h780
`define CSR_ADDR_PCCR_ALL  12'h79F

// operation codes
`define CSR_OP_NONE  2'b00
`define CSR_OP_WRITE 2'b01
`define CSR_OP_SET   2'b10
`define CSR_OP_CLEAR 2'b11

// register index inside the trap block
`define CSR_IDX_MSTATUS  4'd0
`define CSR_IDX_MTVEC    4'd1
`define CSR_IDX_MEPC     4'd2
`define CSR_IDX_MCAUSE   4'd3

// register index inside the counter block, counters sit at 0..7
`define CSR_IDX_PCER     4'd8
`define CSR_IDX_PCMR     4'd9
`define CSR_IDX_PCCR_ALL 4'd15

// mstatus fields
`define CSR_MSTATUS_MIE  3
`define CSR_MSTATUS_MPIE 7
`define CSR_MSTATUS_MPP  12:11
`define CSR_PRIV_M       2'b11

////////////////////////////////////////////////////////////////////////////
// performance counters
////////////////////////////////////////////////////////////////////////////
`define CSR_N_PERF_CNT   8

`define CSR_EV_CYCLES    0
`define CSR_EV_INSTR     1
`define CSR_EV_LD_STALL  2
`define CSR_EV_JUMP      3
`define CSR_EV_BRANCH    4
`define CSR_EV_BR_TAKEN  5
`define CSR_EV_LOAD      6
`define CSR_EV_STORE     7

// pcmr bits and reset value
`define CSR_PCMR_EN      0
`define CSR_PCMR_SAT     1
`define CSR_PCMR_RST     2'd3

`endif

/* hdl/csr_perf_counters.sv */
// performance counter bank
`timescale 1ns/1ps
`include "csr_params.svh"

module csr_perf_counters import csr_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     id_valid_i,
  input  logic     is_decoding_i,
  input  logic     ld_stall_i,
  input  logic     jump_i,
  input  logic     branch_i,
  input  logic     branch_taken_i,
  input  logic     mem_load_i,
  input  logic     mem_store_i,
  csr_bus_if.block bus
);

  localparam int CNT_W = $clog2(`CSR_N_PERF_CNT);

  logic       id_valid_q;
  perf_mask_t ev;
  perf_mask_t inc;
  perf_mask_t inc_q;
  perf_mask_t pcer_q;
  perf_mode_t pcmr_q;
  csr_data_t  cnt_q [`CSR_N_PERF_CNT];

  ////////////////////////////////////////////////////////////////////////////
  // event sources
  ////////////////////////////////////////////////////////////////////////////
  assign ev[`CSR_EV_CYCLES]   = 1'b1;
  assign ev[`CSR_EV_INSTR]    = id_valid_i & is_decoding_i;
  // hazard and flow events qualified by last cycle's id_valid
  assign ev[`CSR_EV_LD_STALL] = ld_stall_i & id_valid_q;
  assign ev[`CSR_EV_JUMP]     = jump_i & id_valid_q;
  assign ev[`CSR_EV_BRANCH]   = branch_i & id_valid_q;
  assign ev[`CSR_EV_BR_TAKEN] = branch_i & branch_taken_i & id_valid_q;
  assign ev[`CSR_EV_LOAD]     = mem_load_i;
  assign ev[`CSR_EV_STORE]    = mem_store_i;

  // per-counter enable and global enable
  assign inc = ev & pcer_q & {`CSR_N_PERF_CNT{pcmr_q[`CSR_PCMR_EN]}};

  // read side
  always_comb begin
    bus.rdata = '0;
    if (bus.idx < csr_reg_t'(`CSR_N_PERF_CNT)) begin
      bus.rdata = cnt_q[bus.idx[CNT_W-1:0]];
    end else if (bus.idx == `CSR_IDX_PCER) begin
      bus.rdata[`CSR_N_PERF_CNT-1:0] = pcer_q;
    end else if (bus.idx == `CSR_IDX_PCMR) begin
      bus.rdata[1:0] = pcmr_q;
    end
    // pccr_all reads zero
  end

  // event stage and config registers
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      id_valid_q <= 1'b0;
      inc_q      <= '0;
      pcer_q     <= '0;
      pcmr_q     <= `CSR_PCMR_RST;
    end else begin
      id_valid_q <= id_valid_i;
      inc_q      <= inc;
      if (bus.we && bus.idx == `CSR_IDX_PCER) begin
        pcer_q <= bus.wdata[`CSR_N_PERF_CNT-1:0];
      end
      if (bus.we && bus.idx == `CSR_IDX_PCMR) begin
        pcmr_q <= bus.wdata[1:0];
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // counters
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `CSR_N_PERF_CNT; i++) begin
        cnt_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < `CSR_N_PERF_CNT; i++) begin
        // csr write beats the pending increment
        if (bus.we && (bus.idx == `CSR_IDX_PCCR_ALL || bus.idx == csr_reg_t'(i))) begin
          cnt_q[i] <= bus.wdata;
        end else if (inc_q[i] && (cnt_q[i] != '1 || !pcmr_q[`CSR_PCMR_SAT])) begin
          // wraps unless saturate holds it at all-ones
          cnt_q[i] <= cnt_q[i] + 32'd1;
        end
      end
    end
  end

endmodule

/* hdl/csr_pkg.sv */
// csr shared types
`include "csr_params.svh"

package csr_pkg;

  // csr address
  typedef logic [11:0] csr_addr_t;

  // data word, also pcs and counters
  typedef logic [31:0] csr_data_t;

  // operation, codes in the params header
  typedef logic [1:0] csr_op_t;

  // register index within one block
  typedef logic [3:0] csr_reg_t;

  // bit 5 marks interrupt, 4:0 the code
  typedef logic [5:0] exc_cause_t;

  // trap vector base, read back shifted by 8
  typedef logic [23:0] tvec_t;

  // one bit per counter
  typedef logic [`CSR_N_PERF_CNT-1:0] perf_mask_t;

  // bit 0 global enable, bit 1 saturate
  typedef logic [1:0] perf_mode_t;

endpackage

/* hdl/csr_read_port.sv */
// csr read mux and rmw data
`timescale 1ns/1ps
`include "csr_params.svh"

module csr_read_port import csr_pkg::*; (
  input  csr_op_t   csr_op_i,
  input  csr_data_t csr_wdata_i,
  output csr_data_t csr_rdata_o,
  csr_bus_if.port   bus_trap,
  csr_bus_if.port   bus_perf
);

  csr_data_t rd_val;
  csr_data_t wr_val;

  ////////////////////////////////////////////////////////////////////////////
  // read select
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin
    if (bus_trap.sel) begin
      rd_val = bus_trap.rdata;
    end else if (bus_perf.sel) begin
      rd_val = bus_perf.rdata;
    end else begin
      // unmapped reads as zero
      rd_val = '0;
    end
  end

  assign csr_rdata_o = rd_val;

  // write data from the current read value
  always_comb begin
    case (csr_op_i)
      `CSR_OP_WRITE: wr_val = csr_wdata_i;
      `CSR_OP_SET:   wr_val = rd_val | csr_wdata_i;
      `CSR_OP_CLEAR: wr_val = rd_val & ~csr_wdata_i;
      // no write strobe for none
      default:       wr_val = csr_wdata_i;
    endcase
  end

  // only the selected block has we
  assign bus_trap.wdata = wr_val;
  assign bus_perf.wdata = wr_val;

endmodule

/* hdl/csr_top.sv */
// machine csr block top
`timescale 1ns/1ps

module csr_top import csr_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,

  // boot and trap vector
  input  tvec_t      boot_addr_i,
  output tvec_t      tvec_o,

  // csr access, single cycle
  input  logic       csr_access_i,
  input  csr_addr_t  csr_addr_i,
  input  csr_data_t  csr_wdata_i,
  input  csr_op_t    csr_op_i,
  output csr_data_t  csr_rdata_o,
  output logic       csr_busy_o,
  output logic       csr_illegal_o,

  // interrupts and exceptions
  output logic       irq_enable_o,
  output csr_data_t  epc_o,
  input  csr_data_t  pc_if_i,
  input  csr_data_t  pc_id_i,
  input  csr_data_t  pc_ex_i,
  input  csr_data_t  branch_target_i,
  input  logic       data_load_event_ex_i,
  input  logic       exc_save_if_i,
  input  logic       exc_save_id_i,
  input  logic       exc_save_takenbranch_i,
  input  logic       exc_restore_mret_i,
  input  exc_cause_t exc_cause_i,
  input  logic       save_exc_cause_i,

  // perf events
  input  logic       id_valid_i,
  input  logic       is_decoding_i,
  input  logic       ld_stall_i,
  input  logic       jump_i,
  input  logic       branch_i,
  input  logic       branch_taken_i,
  input  logic       mem_load_i,
  input  logic       mem_store_i
);

  csr_bus_if bus_trap ();
  csr_bus_if bus_perf ();

  ////////////////////////////////////////////////////////////////////////////
  // address side
  ////////////////////////////////////////////////////////////////////////////
  csr_decode u_decode (
    .csr_access_i  (csr_access_i),
    .csr_addr_i    (csr_addr_i),
    .csr_op_i      (csr_op_i),
    .csr_busy_o    (csr_busy_o),
    .csr_illegal_o (csr_illegal_o),
    .bus_trap      (bus_trap),
    .bus_perf      (bus_perf)
  );

  // mstatus, mepc, mcause, mtvec
  csr_trap_ctrl u_trap (
    .clk                    (clk),
    .rst_n                  (rst_n),
    .boot_addr_i            (boot_addr_i),
    .pc_if_i                (pc_if_i),
    .pc_id_i                (pc_id_i),
    .pc_ex_i                (pc_ex_i),
    .branch_target_i        (branch_target_i),
    .data_load_event_ex_i   (data_load_event_ex_i),
    .exc_save_if_i          (exc_save_if_i),
    .exc_save_id_i          (exc_save_id_i),
    .exc_save_takenbranch_i (exc_save_takenbranch_i),
    .save_exc_cause_i       (save_exc_cause_i),
    .exc_restore_mret_i     (exc_restore_mret_i),
    .exc_cause_i            (exc_cause_i),
    .epc_o                  (epc_o),
    .tvec_o                 (tvec_o),
    .irq_enable_o           (irq_enable_o),
    .bus                    (bus_trap)
  );

  // counters, pcer, pcmr
  csr_perf_counters u_perf (
    .clk            (clk),
    .rst_n          (rst_n),
    .id_valid_i     (id_valid_i),
    .is_decoding_i  (is_decoding_i),
    .ld_stall_i     (ld_stall_i),
    .jump_i         (jump_i),
    .branch_i       (branch_i),
    .branch_taken_i (branch_taken_i),
    .mem_load_i     (mem_load_i),
    .mem_store_i    (mem_store_i),
    .bus            (bus_perf)
  );

  // read data out, rmw data back in
  csr_read_port u_read (
    .csr_op_i    (csr_op_i),
    .csr_wdata_i (csr_wdata_i),
    .csr_rdata_o (csr_rdata_o),
    .bus_trap    (bus_trap),
    .bus_perf    (bus_perf)
  );

endmodule

/* hdl/csr_trap_ctrl.sv */
// machine trap registers
`timescale 1ns/1ps
`include "csr_params.svh"

module csr_trap_ctrl import csr_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  tvec_t      boot_addr_i,
  input  csr_data_t  pc_if_i,
  input  csr_data_t  pc_id_i,
  input  csr_data_t  pc_ex_i,
  input  csr_data_t  branch_target_i,
  input  logic       data_load_event_ex_i,
  input  logic       exc_save_if_i,
  input  logic       exc_save_id_i,
  input  logic       exc_save_takenbranch_i,
  input  logic       save_exc_cause_i,
  input  logic       exc_restore_mret_i,
  input  exc_cause_t exc_cause_i,
  output csr_data_t  epc_o,
  output tvec_t      tvec_o,
  output logic       irq_enable_o,
  csr_bus_if.block   bus
);

  // mstatus, only the two enables are stored
  logic       mie_q;
  logic       mpie_q;
  csr_data_t  mepc_q;
  exc_cause_t mcause_q;
  tvec_t      mtvec_q;

  csr_data_t  exc_pc;

  ////////////////////////////////////////////////////////////////////////////
  // exception pc select
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin
    // load fault in ex wins
    if (data_load_event_ex_i) begin
      exc_pc = pc_ex_i;
    end else if (exc_save_if_i) begin
      exc_pc = pc_if_i;
    end else if (exc_save_id_i) begin
      exc_pc = pc_id_i;
    end else if (exc_save_takenbranch_i) begin
      exc_pc = branch_target_i;
    end else begin
      // fallback, instruction in decode
      exc_pc = pc_id_i;
    end
  end

  // read side
  always_comb begin
    bus.rdata = '0;
    case (bus.idx)
      `CSR_IDX_MSTATUS: begin
        bus.rdata[`CSR_MSTATUS_MIE]  = mie_q;
        bus.rdata[`CSR_MSTATUS_MPIE] = mpie_q;
        // always machine mode
        bus.rdata[`CSR_MSTATUS_MPP]  = `CSR_PRIV_M;
      end
      `CSR_IDX_MTVEC:  bus.rdata = {mtvec_q, 8'h00};
      `CSR_IDX_MEPC:   bus.rdata = mepc_q;
      `CSR_IDX_MCAUSE: bus.rdata = {mcause_q[5], 26'b0, mcause_q[4:0]};
      default:         bus.rdata = '0;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // state update, trap > mret > csr write
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mie_q    <= 1'b0;
      mpie_q   <= 1'b0;
      mepc_q   <= '0;
      mcause_q <= '0;
      // vector starts at boot address
      mtvec_q  <= boot_addr_i;
    end else if (save_exc_cause_i) begin
      mepc_q   <= exc_pc;
      mcause_q <= exc_cause_i;
      mpie_q   <= mie_q;
      mie_q    <= 1'b0;
    end else if (exc_restore_mret_i) begin
      mie_q    <= mpie_q;
      mpie_q   <= 1'b1;
    end else if (bus.we) begin
      case (bus.idx)
        `CSR_IDX_MSTATUS: begin
          mie_q  <= bus.wdata[`CSR_MSTATUS_MIE];
          mpie_q <= bus.wdata[`CSR_MSTATUS_MPIE];
        end
        // low byte of mtvec is hardwired zero
        `CSR_IDX_MTVEC:  mtvec_q  <= bus.wdata[31:8];
        `CSR_IDX_MEPC:   mepc_q   <= bus.wdata;
        `CSR_IDX_MCAUSE: mcause_q <= {bus.wdata[31], bus.wdata[4:0]};
        default: ;
      endcase
    end
  end

  // straight to the core
  assign epc_o        = mepc_q;
  assign tvec_o       = mtvec_q;
  assign irq_enable_o = mie_q;

endmodule

/* run.sh */
#!/bin/sh
# build and run the csr testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
  --top-module csr_tb -f sim.f -o csr_sim \
  && ./obj_dir/csr_sim | tee /dev/stderr | grep -x "Simulation passed" > /dev/null \
  && echo "run.sh: PASS" \
  || { echo "run.sh: FAIL"; exit 1; }

/* sim.f */
+incdir+hdl
hdl/csr_pkg.sv
hdl/csr_bus_if.sv
hdl/csr_decode.sv
hdl/csr_trap_ctrl.sv
hdl/csr_perf_counters.sv
hdl/csr_read_port.sv
hdl/csr_top.sv
tb/csr_assertions.sv
tb/csr_tb.sv

/* tb/csr_assertions.sv */
// csr block invariants
`timescale 1ns/1ps

module csr_assertions import csr_pkg::*; (
  input logic      clk,
  input logic      rst_n,
  input logic      data_load_event_ex_i,
  input logic      exc_save_takenbranch_i,
  input logic      save_exc_cause_i,
  input logic      exc_restore_mret_i,
  input logic      csr_illegal_o,
  input csr_data_t csr_rdata_o
);

  ////////////////////////////////////////////////////////////////////////////
  // pipeline inputs
  ////////////////////////////////////////////////////////////////////////////
  // load fault and taken branch are exclusive pc sources
  pc_src_excl: assert property (@(posedge clk) disable iff (!rst_n)
    !(data_load_event_ex_i && exc_save_takenbranch_i))
    else $error("load event and taken-branch save high in the same cycle");

  // trap entry and mret never together
  trap_mret_excl: assert property (@(posedge clk) disable iff (!rst_n)
    !(save_exc_cause_i && exc_restore_mret_i))
    else $error("trap entry and mret high in the same cycle");

  ////////////////////////////////////////////////////////////////////////////
  // outputs
  ////////////////////////////////////////////////////////////////////////////
  // unmapped access returns zero
  illegal_reads_zero: assert property (@(posedge clk) disable iff (!rst_n)
    csr_illegal_o |-> (csr_rdata_o == '0))
    else $error("illegal access returned nonzero read data");

endmodule

bind csr_top csr_assertions u_assertions (
  .clk                    (clk),
  .rst_n                  (rst_n),
  .data_load_event_ex_i   (data_load_event_ex_i),
  .exc_save_takenbranch_i (exc_save_takenbranch_i),
  .save_exc_cause_i       (save_exc_cause_i),
  .exc_restore_mret_i     (exc_restore_mret_i),
  .csr_illegal_o          (csr_illegal_o),
  .csr_rdata_o            (csr_rdata_o)
);

/* tb/csr_tb.sv */
// csr block testbench
`timescale 1ns/1ps
`include "csr_params.svh"

module csr_tb import csr_pkg::*; ();

  logic       clk;
  logic       rst_n;
  tvec_t      boot_addr_i;
  tvec_t      tvec_o;
  logic       csr_access_i;
  csr_addr_t  csr_addr_i;
  csr_data_t  csr_wdata_i;
  csr_op_t    csr_op_i;
  csr_data_t  csr_rdata_o;
  logic       csr_busy_o;
  logic       csr_illegal_o;
  logic       irq_enable_o;
  csr_data_t  epc_o;
  csr_data_t  pc_if_i;
  csr_data_t  pc_id_i;
  csr_data_t  pc_ex_i;
  csr_data_t  branch_target_i;
  logic       data_load_event_ex_i;
  logic       exc_save_if_i;
  logic       exc_save_id_i;
  logic       exc_save_takenbranch_i;
  logic       exc_restore_mret_i;
  exc_cause_t exc_cause_i;
  logic       save_exc_cause_i;
  logic       id_valid_i;
  logic       is_decoding_i;
  logic       ld_stall_i;
  logic       jump_i;
  logic       branch_i;
  logic       branch_taken_i;
  logic       mem_load_i;
  logic       mem_store_i;

  int         mismatch_cnt;
  int         fail_cnt;
  // posedges seen since time zero
  int         cyc_cnt;
  csr_data_t  lcg_state;

  csr_top DUT (.*);

  // 20 ns clock
  always #10 clk = ~clk;

  always @(posedge clk) cyc_cnt <= cyc_cnt + 1;

  ////////////////////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////////////////////
  function automatic csr_data_t next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic check_data(input string name, input csr_data_t got, input csr_data_t exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
      mismatch_cnt++;
    end
  endtask

  task automatic check_cause(input string name, input exc_cause_t got, input exc_cause_t exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
      mismatch_cnt++;
    end
  endtask

  task automatic check_tvec(input string name, input tvec_t got, input tvec_t exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
      mismatch_cnt++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s got %b expected %b", $time, name, got, exp);
      mismatch_cnt++;
    end
  endtask

  // one access cycle, sampled mid-cycle
  task automatic write_csr(input csr_addr_t addr, input csr_op_t op, input csr_data_t data,
                           output logic busy);
    @(posedge clk);
    csr_access_i <= 1'b1;
    csr_addr_i   <= addr;
    csr_op_i     <= op;
    csr_wdata_i  <= data;
    @(negedge clk);
    busy = csr_busy_o;
  endtask

  task automatic write_reg(input csr_addr_t addr, input csr_data_t data);
    logic busy;
    write_csr(addr, `CSR_OP_WRITE, data, busy);
  endtask

  task automatic read_csr(input csr_addr_t addr, output csr_data_t data, output logic illegal);
    @(posedge clk);
    csr_access_i <= 1'b1;
    csr_addr_i   <= addr;
    csr_op_i     <= `CSR_OP_NONE;
    @(negedge clk);
    data    = csr_rdata_o;
    illegal = csr_illegal_o;
  endtask

  task automatic expect_read(input string name, input csr_addr_t addr, input csr_data_t exp);
    csr_data_t d;
    logic      ill;
    read_csr(addr, d, ill);
    check_data(name, d, exp);
    check_bit({name, " illegal"}, ill, 1'b0);
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      csr_access_i <= 1'b0;
      csr_op_i     <= `CSR_OP_NONE;
    end
  endtask

  // poll a counter every cycle until it holds exp
  task automatic wait_counter(input int idx, input csr_data_t exp, input int limit);
    csr_data_t d;
    logic      ill;
    int        n;
    n = 0;
    d = ~exp;
    while (d !== exp && n < limit) begin
      read_csr(`CSR_ADDR_PCCR_BASE + csr_addr_t'(idx), d, ill);
      n++;
    end
    if (d !== exp) begin
      $display("TIMEOUT at %0t: counter %0d did not reach %h in %0d cycles",
               $time, idx, exp, limit);
      fail_cnt++;
    end
  endtask

  task automatic drive_loads(input int k);
    repeat (k) begin
      @(posedge clk);
      csr_access_i <= 1'b0;
      csr_op_i     <= `CSR_OP_NONE;
      mem_load_i   <= 1'b1;
    end
    @(posedge clk);
    mem_load_i <= 1'b0;
  endtask

  task automatic pulse_mret();
    @(posedge clk);
    csr_access_i       <= 1'b0;
    csr_op_i           <= `CSR_OP_NONE;
    exc_restore_mret_i <= 1'b1;
    @(posedge clk);
    exc_restore_mret_i <= 1'b0;
    @(negedge clk);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////////////////////////////////////////
  task automatic reset_and_illegal();
    csr_addr_t bad [3];
    csr_data_t d;
    logic      ill;
    bad = '{12'h123, 12'h788, 12'h7A2};
    @(negedge clk);
    check_bit("irq_enable_o", irq_enable_o, 1'b0);
    check_bit("csr_busy_o", csr_busy_o, 1'b0);
    check_tvec("tvec_o", tvec_o, boot_addr_i);
    expect_read("mtvec", `CSR_ADDR_MTVEC, {boot_addr_i, 8'h00});
    expect_read("pcmr", `CSR_ADDR_PCMR, 32'd3);
    expect_read("pcer", `CSR_ADDR_PCER, 32'd0);
    expect_read("pccr6", `CSR_ADDR_PCCR_BASE + 12'd6, 32'd0);
    // unmapped, including one past the last counter
    for (int i = 0; i < 3; i++) begin
      read_csr(bad[i], d, ill);
      check_data("csr_rdata_o unmapped", d, 32'd0);
      check_bit("csr_illegal_o", ill, 1'b1);
    end
  endtask

  task automatic reg_access();
    csr_addr_t addrs [3];
    csr_data_t wmask [3];
    csr_data_t ro_bits [3];
    string     names [3];
    csr_op_t   ops [3];
    csr_data_t cur;
    csr_data_t d;
    csr_data_t exp;
    logic      busy;
    addrs   = '{`CSR_ADDR_MEPC, `CSR_ADDR_MTVEC, `CSR_ADDR_MSTATUS};
    // writable fields per register
    wmask   = '{32'hFFFF_FFFF, 32'hFFFF_FF00, 32'h0000_0088};
    // mpp reads as machine mode
    ro_bits = '{32'h0, 32'h0, 32'h0000_1800};
    names   = '{"mepc", "mtvec", "mstatus"};
    ops     = '{`CSR_OP_WRITE, `CSR_OP_SET, `CSR_OP_CLEAR};
    for (int r = 0; r < 3; r++) begin
      cur = ro_bits[r];
      for (int i = 0; i < 6; i++) begin
        d = next_rand();
        case (ops[i % 3])
          `CSR_OP_WRITE: exp = d;
          `CSR_OP_SET:   exp = cur | d;
          default:       exp = cur & ~d;
        endcase
        exp = (exp & wmask[r]) | ro_bits[r];
        write_csr(addrs[r], ops[i % 3], d, busy);
        // stall only for mepc and mtvec
        check_bit("csr_busy_o", busy, r < 2);
        expect_read(names[r], addrs[r], exp);
        // vector output tracks mtvec
        if (r == 1) begin
          check_tvec("tvec_o", tvec_o, exp[31:8]);
        end
        cur = exp;
      end
    end
  endtask

  task automatic trap_entry();
    csr_data_t  p_if;
    csr_data_t  p_id;
    csr_data_t  p_ex;
    csr_data_t  p_br;
    csr_data_t  exp_pc;
    csr_data_t  d;
    exc_cause_t cause;
    logic       ill;
    // 0 load event, 1 if, 2 id, 3 taken branch, 4 no flag
    for (int s = 0; s < 5; s++) begin
      write_reg(`CSR_ADDR_MSTATUS, 32'h8);
      p_if  = next_rand();
      p_id  = next_rand();
      p_ex  = next_rand();
      p_br  = next_rand();
      cause = exc_cause_t'(next_rand() >> 7);
      case (s)
        0:       exp_pc = p_ex;
        1:       exp_pc = p_if;
        3:       exp_pc = p_br;
        default: exp_pc = p_id;
      endcase
      @(posedge clk);
      csr_access_i           <= 1'b0;
      csr_op_i               <= `CSR_OP_NONE;
      pc_if_i                <= p_if;
      pc_id_i                <= p_id;
      pc_ex_i                <= p_ex;
      branch_target_i        <= p_br;
      data_load_event_ex_i   <= (s == 0);
      exc_save_if_i          <= (s == 1);
      exc_save_id_i          <= (s == 2);
      exc_save_takenbranch_i <= (s == 3);
      exc_cause_i            <= cause;
      save_exc_cause_i       <= 1'b1;
      @(posedge clk);
      data_load_event_ex_i   <= 1'b0;
      exc_save_if_i          <= 1'b0;
      exc_save_id_i          <= 1'b0;
      exc_save_takenbranch_i <= 1'b0;
      save_exc_cause_i       <= 1'b0;
      @(negedge clk);
      check_data("epc_o", epc_o, exp_pc);
      check_bit("irq_enable_o", irq_enable_o, 1'b0);
      expect_read("mepc", `CSR_ADDR_MEPC, exp_pc);
      read_csr(`CSR_ADDR_MCAUSE, d, ill);
      check_cause("mcause", {d[31], d[4:0]}, cause);
      check_data("mcause", d, {cause[5], 26'b0, cause[4:0]});
      // mie cleared, old mie in mpie
      expect_read("mstatus", `CSR_ADDR_MSTATUS, 32'h0000_1880);
    end
  endtask

  task automatic mret_restore();
    write_reg(`CSR_ADDR_MSTATUS, 32'h80);
    pulse_mret();
    check_bit("irq_enable_o", irq_enable_o, 1'b1);
    expect_read("mstatus", `CSR_ADDR_MSTATUS, 32'h0000_1888);
    write_reg(`CSR_ADDR_MSTATUS, 32'h0);
    pulse_mret();
    check_bit("irq_enable_o", irq_enable_o, 1'b0);
    expect_read("mstatus", `CSR_ADDR_MSTATUS, 32'h0000_1880);
  endtask

  task automatic event_counting();
    csr_data_t c0;
    csr_data_t c1;
    logic      ill;
    int        t0;
    int        t1;
    int        k;
    k = 3 + int'(next_rand() % 32'd12);
    write_reg(`CSR_ADDR_PCMR, 32'h0);
    write_reg(`CSR_ADDR_PCCR_ALL, 32'h0);
    write_reg(`CSR_ADDR_PCER, (32'h1 << `CSR_EV_LOAD) | (32'h1 << `CSR_EV_CYCLES));
    write_reg(`CSR_ADDR_PCMR, 32'h1);
    // let the increment stage fill
    idle_cycles(3);
    read_csr(`CSR_ADDR_PCCR_BASE, c0, ill);
    t0 = cyc_cnt;
    drive_loads(k);
    wait_counter(`CSR_EV_LOAD, csr_data_t'(k), 10);
    idle_cycles(3);
    expect_read("pccr6", `CSR_ADDR_PCCR_BASE + 12'd6, csr_data_t'(k));
    read_csr(`CSR_ADDR_PCCR_BASE, c1, ill);
    t1 = cyc_cnt;
    check_data("pccr0 delta", c1 - c0, csr_data_t'(t1 - t0));
    // global enable off, nothing moves
    write_reg(`CSR_ADDR_PCMR, 32'h0);
    idle_cycles(3);
    read_csr(`CSR_ADDR_PCCR_BASE, c0, ill);
    drive_loads(4);
    idle_cycles(3);
    expect_read("pccr0 held", `CSR_ADDR_PCCR_BASE, c0);
    expect_read("pccr6 held", `CSR_ADDR_PCCR_BASE + 12'd6, csr_data_t'(k));
  endtask

  task automatic saturate_and_wrap();
    csr_data_t d;
    logic      ill;
    int        n;
    write_reg(`CSR_ADDR_PCER, 32'h1 << `CSR_EV_CYCLES);
    write_reg(`CSR_ADDR_PCMR, 32'h3);
    write_reg(`CSR_ADDR_PCCR_BASE, 32'hFFFF_FFFE);
    wait_counter(`CSR_EV_CYCLES, 32'hFFFF_FFFF, 10);
    idle_cycles(4);
    expect_read("pccr0 saturated", `CSR_ADDR_PCCR_BASE, 32'hFFFF_FFFF);
    write_reg(`CSR_ADDR_PCMR, 32'h1);
    // first value past all-ones must be zero
    d = 32'hFFFF_FFFF;
    n = 0;
    while (d === 32'hFFFF_FFFF && n < 10) begin
      read_csr(`CSR_ADDR_PCCR_BASE, d, ill);
      n++;
    end
    if (d === 32'hFFFF_FFFF) begin
      $display("TIMEOUT at %0t: counter 0 never wrapped with saturate clear", $time);
      fail_cnt++;
    end else begin
      check_data("pccr0 wrapped", d, 32'h0);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////////////////////
  initial begin
    clk                    = 1'b0;
    rst_n                  = 1'b0;
    boot_addr_i            = 24'h1C0008;
    csr_access_i           = 1'b0;
    csr_addr_i             = '0;
    csr_wdata_i            = '0;
    csr_op_i               = `CSR_OP_NONE;
    pc_if_i                = '0;
    pc_id_i                = '0;
    pc_ex_i                = '0;
    branch_target_i        = '0;
    data_load_event_ex_i   = 1'b0;
    exc_save_if_i          = 1'b0;
    exc_save_id_i          = 1'b0;
    exc_save_takenbranch_i = 1'b0;
    exc_restore_mret_i     = 1'b0;
    exc_cause_i            = '0;
    save_exc_cause_i       = 1'b0;
    id_valid_i             = 1'b0;
    is_decoding_i          = 1'b0;
    ld_stall_i             = 1'b0;
    jump_i                 = 1'b0;
    branch_i               = 1'b0;
    branch_taken_i         = 1'b0;
    mem_load_i             = 1'b0;
    mem_store_i            = 1'b0;
    mismatch_cnt           = 0;
    fail_cnt               = 0;
    cyc_cnt                = 0;
    lcg_state              = 32'd54886;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    reset_and_illegal();
    reg_access();
    trap_entry();
    mret_restore();
    event_counting();
    saturate_and_wrap();
    idle_cycles(2);
    $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
    if (mismatch_cnt == 0 && fail_cnt == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule
